// ==== hdl/socket_pkg.sv ====
// ##########################################################
// Host-side definitions for the Forth CPU socket.
// Wishbone address and data widths, the word address map
// and the signature constant.
// ##########################################################
package socket_pkg;

  // Wishbone word address and data word.
  typedef logic [17:0] wb_addr_t;
  typedef logic [31:0] word_t;

  // Program memory size in 32-bit words.
  localparam int unsigned MEM_WORDS = 8192;
  localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);

  // Register space starts right after the program memory.
  localparam wb_addr_t REG_BASE = wb_addr_t'(MEM_WORDS);

  // Register word offsets from REG_BASE.
  localparam wb_addr_t REG_IRQ_IN = 18'd1;
  localparam wb_addr_t REG_CTRL   = 18'd2;
  localparam wb_addr_t REG_RX     = 18'd16;
  localparam wb_addr_t REG_GP_IN  = 18'd17;
  localparam wb_addr_t REG_TX     = 18'd18;
  localparam wb_addr_t REG_GP_OUT = 18'd19;

  // Signature lives at the very top of the address range.
  localparam wb_addr_t REG_SIG_ADDR = 18'h3ffff;
  localparam word_t    SIGNATURE    = 32'hf041011b;

endpackage

// ==== hdl/core_io_pkg.sv ====
// ##########################################################
// Core-side definitions for the Forth CPU socket.
// Address, instruction and byte widths, the core I/O map
// and the clock rate constants.
// ##########################################################
package core_io_pkg;

  typedef logic [15:0] io_addr_t;
  typedef logic [12:0] code_addr_t;
  typedef logic [15:0] insn_t;
  typedef logic [7:0]  byte_t;

  // Core I/O map.
  localparam io_addr_t IO_UART_DATA = 16'h1000;
  localparam io_addr_t IO_UART_STAT = 16'h2000;
  localparam io_addr_t IO_FREQ      = 16'h1010;
  localparam io_addr_t IO_CLK_LO    = 16'h1014;
  localparam io_addr_t IO_CLK_HI    = 16'h1018;
  localparam io_addr_t IO_MS        = 16'h101c;

  // GPIO window is the page with upper byte zero.
  localparam logic [7:0] IO_GPIO_PAGE = 8'h00;

  // Clock rate and millisecond prescale.
  localparam int unsigned CLK_MHZ = 50;
  localparam int unsigned CLK_HZ  = CLK_MHZ * 1000000;
  localparam int unsigned MS_DIV  = CLK_MHZ * 1000;

endpackage

// ==== hdl/prog_ram.sv ====
// ##########################################################
// Dual-port program RAM for the Forth CPU.
// Port A is a 32-bit read/write data port.
// Port B is a 16-bit instruction fetch port.
// ##########################################################
`timescale 1ns/1ps

module prog_ram (
  input  logic                         sys_clk,
  input  logic [socket_pkg::MEM_AW-1:0] a_addr_i,
  input  logic                         a_wr_i,
  input  socket_pkg::word_t            a_din_i,
  output socket_pkg::word_t            a_dout_o,
  input  core_io_pkg::code_addr_t      b_addr_i,
  output core_io_pkg::insn_t           b_insn_o
);
  import socket_pkg::*;

  // Shared storage.
  word_t mem [MEM_WORDS];

  word_t b_word_q;
  logic  b_hi_q;

  // Port A.
  // Read-first, so a write returns the old word.
  always_ff @(posedge sys_clk) begin
    a_dout_o <= mem[a_addr_i];
    if (a_wr_i) begin
      mem[a_addr_i] <= a_din_i;
    end
  end

  // Port B.
  // Two instructions per word, lower half of memory only.
  always_ff @(posedge sys_clk) begin
    b_word_q <= mem[{1'b0, b_addr_i[12:1]}];
    b_hi_q   <= b_addr_i[0];
  end

  // Even code addresses take the low half-word.
  assign b_insn_o = b_hi_q ? b_word_q[31:16] : b_word_q[15:0];

endmodule

// ==== hdl/wb_host_port.sv ====
// ##########################################################
// Wishbone slave front of the socket.
// Memory/register decode, ack timing, read data select
// and sharing of the RAM data port with the core.
// ##########################################################
`timescale 1ns/1ps

module wb_host_port (
  input  logic                          sys_clk,
  input  logic                          rst,
  input  logic                          wbs_cyc_i,
  input  logic                          wbs_stb_i,
  input  logic                          wbs_we_i,
  input  socket_pkg::wb_addr_t          wbs_adr_i,
  input  socket_pkg::word_t             wbs_dat_i,
  output logic                          wbs_ack_o,
  output socket_pkg::word_t             wbs_dat_o,
  input  logic                          core_run_i,
  input  core_io_pkg::io_addr_t         core_addr_i,
  input  logic                          core_wr_i,
  input  socket_pkg::word_t             core_dout_i,
  output logic [socket_pkg::MEM_AW-1:0] ram_addr_o,
  output logic                          ram_wr_o,
  output socket_pkg::word_t             ram_din_o,
  input  socket_pkg::word_t             ram_dout_i,
  output logic                          reg_wr_o,
  output logic                          reg_rd_o,
  output socket_pkg::wb_addr_t          reg_off_o,
  output socket_pkg::word_t             reg_wdata_o,
  input  socket_pkg::word_t             reg_rdata_i
);
  import socket_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_ACK
  } state_t;

  state_t state_q;
  logic   mem_hit;
  logic   start;
  word_t  mem_rdata_q;

  // Addresses below REG_BASE hit program memory.
  assign mem_hit = (wbs_adr_i < REG_BASE);

  // A new access is only taken from idle.
  assign start = wbs_cyc_i & wbs_stb_i & (state_q == ST_IDLE);

  // Memory reads wait one extra cycle for the RAM.
  always_ff @(posedge sys_clk) begin
    if (rst || !wbs_cyc_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            state_q <= (mem_hit && !wbs_we_i) ? ST_WAIT : ST_ACK;
          end
        end
        ST_WAIT: state_q <= ST_ACK;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign wbs_ack_o = (state_q == ST_ACK) & wbs_cyc_i;

  // RAM output staged so it lines up with the ack.
  always_ff @(posedge sys_clk) begin
    mem_rdata_q <= ram_dout_i;
  end

  assign wbs_dat_o = mem_hit ? mem_rdata_q : reg_rdata_i;

  // Register strobes are one-cycle pulses.
  assign reg_wr_o    = start & wbs_we_i & ~mem_hit;
  assign reg_rd_o    = start & ~wbs_we_i & ~mem_hit;
  assign reg_off_o   = wbs_adr_i - REG_BASE;
  assign reg_wdata_o = wbs_dat_i;

  // Running core owns the data port; host writes are dropped then.
  // Core addresses bytes, so drop the two low bits.
  assign ram_addr_o = core_run_i ? core_addr_i[MEM_AW+1:2] : wbs_adr_i[MEM_AW-1:0];
  assign ram_wr_o   = core_run_i ? core_wr_i : (start & wbs_we_i & mem_hit);
  assign ram_din_o  = core_run_i ? core_dout_i : wbs_dat_i;

endmodule

// ==== hdl/host_regs.sv ====
// ##########################################################
// Host-visible registers of the socket.
// Control, sampled irq inputs, GP input, signature,
// the register read mux and the mailbox host strobes.
// ##########################################################
`timescale 1ns/1ps

module host_regs (
  input  logic                 sys_clk,
  input  logic                 rst,
  input  logic                 reg_wr_i,
  input  logic                 reg_rd_i,
  input  socket_pkg::wb_addr_t reg_off_i,
  input  socket_pkg::word_t    reg_wdata_i,
  output socket_pkg::word_t    reg_rdata_o,
  input  socket_pkg::word_t    irq_in_i,
  output logic                 core_run_o,
  output socket_pkg::word_t    gp_in_o,
  output logic                 rx_load_o,
  output core_io_pkg::byte_t   rx_byte_o,
  output logic                 tx_ack_o,
  input  core_io_pkg::byte_t   rx_byte_i,
  input  logic                 rx_avail_i,
  input  core_io_pkg::byte_t   tx_byte_i,
  input  logic                 tx_busy_i,
  input  socket_pkg::word_t    gp_out_i
);
  import socket_pkg::*;

  // Signature offset relative to the register base.
  localparam wb_addr_t SIG_OFF = REG_SIG_ADDR - REG_BASE;

  word_t ctrl_q;
  word_t irq_in_q;
  word_t gp_in_q;
  word_t rdata_q;

  // Control state and sampled inputs.
  always_ff @(posedge sys_clk) begin
    if (rst) begin
      ctrl_q   <= '0;
      irq_in_q <= '0;
      gp_in_q  <= '0;
    end else begin
      // irq inputs are sampled every cycle.
      irq_in_q <= irq_in_i;
      if (reg_wr_i) begin
        case (reg_off_i)
          REG_CTRL:  ctrl_q  <= reg_wdata_i;
          REG_GP_IN: gp_in_q <= reg_wdata_i;
          default: ;
        endcase
      end
    end
  end

  // Read mux.
  // Data is ready in the cycle after the read strobe.
  always_ff @(posedge sys_clk) begin
    if (reg_rd_i) begin
      case (reg_off_i)
        REG_IRQ_IN: rdata_q <= irq_in_q;
        REG_CTRL:   rdata_q <= ctrl_q;
        // Byte with its available flag above it.
        REG_RX:     rdata_q <= {23'b0, rx_avail_i, rx_byte_i};
        REG_GP_IN:  rdata_q <= gp_in_q;
        // Busy here means a byte waits for the host.
        REG_TX:     rdata_q <= {23'b0, tx_busy_i, tx_byte_i};
        REG_GP_OUT: rdata_q <= gp_out_i;
        SIG_OFF:    rdata_q <= SIGNATURE;
        default:    rdata_q <= '0;
      endcase
    end
  end

  assign reg_rdata_o = rdata_q;

  // Bit 0 of ctrl releases the core.
  assign core_run_o = ctrl_q[0];
  assign gp_in_o    = gp_in_q;

  // Host writes a byte for the core.
  assign rx_load_o = reg_wr_i && (reg_off_i == REG_RX);
  assign rx_byte_o = reg_wdata_i[7:0];

  // Reading REG_TX takes the byte and clears busy.
  assign tx_ack_o = reg_rd_i && (reg_off_i == REG_TX);

endmodule

// ==== hdl/uart_mailbox.sv ====
// ##########################################################
// One-byte serial mailbox between host and core.
// Receive byte with available flag, transmit byte with
// busy flag.
// ##########################################################
`timescale 1ns/1ps

module uart_mailbox (
  input  logic               sys_clk,
  input  logic               rst,
  input  logic               rx_load_i,
  input  core_io_pkg::byte_t rx_byte_i,
  input  logic               rx_take_i,
  output core_io_pkg::byte_t rx_byte_o,
  output logic               rx_avail_o,
  input  logic               tx_load_i,
  input  core_io_pkg::byte_t tx_byte_i,
  input  logic               tx_ack_i,
  output core_io_pkg::byte_t tx_byte_o,
  output logic               tx_busy_o
);

  // Flags.
  // A load wins over a clear in the same cycle.
  always_ff @(posedge sys_clk) begin
    if (rst) begin
      rx_avail_o <= 1'b0;
      tx_busy_o  <= 1'b0;
    end else begin
      if (rx_load_i) begin
        rx_avail_o <= 1'b1;
      end else if (rx_take_i) begin
        rx_avail_o <= 1'b0;
      end
      if (tx_load_i) begin
        tx_busy_o <= 1'b1;
      end else if (tx_ack_i) begin
        tx_busy_o <= 1'b0;
      end
    end
  end

  // Byte holders.
  always_ff @(posedge sys_clk) begin
    if (rx_load_i) rx_byte_o <= rx_byte_i;
    if (tx_load_i) tx_byte_o <= tx_byte_i;
  end

endmodule

// ==== hdl/core_io_bridge.sv ====
// ##########################################################
// Core I/O bridge.
// I/O read decode, delayed write decode, GP outputs,
// 64-bit cycle counter with snapshot, millisecond uptime.
// ##########################################################
`timescale 1ns/1ps

module core_io_bridge (
  input  logic                  sys_clk,
  input  logic                  rst,
  input  core_io_pkg::io_addr_t core_mem_addr_i,
  input  logic                  core_io_rd_i,
  input  logic                  core_io_wr_i,
  input  socket_pkg::word_t     core_dout_i,
  output socket_pkg::word_t     core_io_din_o,
  input  socket_pkg::word_t     gp_in_i,
  output socket_pkg::word_t     gp_out_o,
  input  core_io_pkg::byte_t    rx_byte_i,
  input  logic                  rx_avail_i,
  output logic                  rx_take_o,
  input  logic                  tx_busy_i,
  output logic                  tx_load_o,
  output core_io_pkg::byte_t    tx_byte_o
);
  import socket_pkg::*;
  import core_io_pkg::*;

  localparam int unsigned SUB_W = $clog2(MS_DIV);

  logic [63:0]      cycle_q;
  logic [63:0]      snap_q;
  logic [SUB_W-1:0] sub_q;
  word_t            ms_q;

  logic     wr_q;
  logic     rd_q;
  io_addr_t addr_q;
  word_t    dout_q;

  // Free-running counters.
  always_ff @(posedge sys_clk) begin
    if (rst) begin
      cycle_q <= '0;
      sub_q   <= '0;
      ms_q    <= '0;
    end else begin
      cycle_q <= cycle_q + 64'd1;
      // Prescaler wraps once per millisecond.
      if (sub_q == SUB_W'(MS_DIV - 1)) begin
        sub_q <= '0;
        ms_q  <= ms_q + 32'd1;
      end else begin
        sub_q <= sub_q + 1'b1;
      end
    end
  end

  // Core strobes are staged one cycle.
  always_ff @(posedge sys_clk) begin
    if (rst) begin
      wr_q <= 1'b0;
      rd_q <= 1'b0;
    end else begin
      wr_q <= core_io_wr_i;
      rd_q <= core_io_rd_i;
    end
    addr_q <= core_mem_addr_i;
    dout_q <= core_dout_i;
  end

  // Delayed writes to GP outputs and the snapshot.
  always_ff @(posedge sys_clk) begin
    if (rst) begin
      gp_out_o <= '0;
      snap_q   <= '0;
    end else if (wr_q) begin
      if (addr_q[15:8] == IO_GPIO_PAGE) begin
        gp_out_o[addr_q[4:0]] <= dout_q[0];
      end
      if (addr_q == IO_FREQ) begin
        snap_q <= cycle_q;
      end
    end
  end

  // Mailbox strobes from the staged access.
  assign tx_load_o = wr_q && (addr_q == IO_UART_DATA);
  assign tx_byte_o = dout_q[7:0];
  assign rx_take_o = rd_q && (addr_q == IO_UART_DATA);

  // Read data follows the address by one cycle.
  always_ff @(posedge sys_clk) begin
    if (core_mem_addr_i[15:8] == IO_GPIO_PAGE) begin
      core_io_din_o <= {31'b0, gp_in_i[core_mem_addr_i[4:0]]};
    end else begin
      case (core_mem_addr_i)
        IO_UART_DATA: core_io_din_o <= {24'b0, rx_byte_i};
        // Bit 0 means ready to transmit.
        IO_UART_STAT: core_io_din_o <= {30'b0, rx_avail_i, ~tx_busy_i};
        IO_FREQ:      core_io_din_o <= word_t'(CLK_HZ);
        IO_CLK_LO:    core_io_din_o <= snap_q[31:0];
        IO_CLK_HI:    core_io_din_o <= snap_q[63:32];
        IO_MS:        core_io_din_o <= ms_q;
        default:      core_io_din_o <= '0;
      endcase
    end
  end

endmodule

// ==== hdl/forth_socket_top.sv ====
// ##########################################################
// Top level of the Forth CPU socket frontend.
// Host port, program RAM, registers, mailbox, I/O bridge.
// ##########################################################
`timescale 1ns/1ps

module forth_socket_top (
  input  logic                    sys_clk,
  input  logic                    rst,
  input  logic                    wbs_cyc_i,
  input  logic                    wbs_stb_i,
  input  logic                    wbs_we_i,
  input  socket_pkg::wb_addr_t    wbs_adr_i,
  input  socket_pkg::word_t       wbs_dat_i,
  output logic                    wbs_ack_o,
  output socket_pkg::word_t       wbs_dat_o,
  input  socket_pkg::word_t       irq_in_i,
  output logic                    core_rst_n_o,
  input  core_io_pkg::io_addr_t   core_mem_addr_i,
  input  logic                    core_mem_wr_i,
  input  socket_pkg::word_t       core_dout_i,
  input  logic                    core_io_rd_i,
  input  logic                    core_io_wr_i,
  output socket_pkg::word_t       core_mem_din_o,
  output socket_pkg::word_t       core_io_din_o,
  input  core_io_pkg::code_addr_t core_code_addr_i,
  output core_io_pkg::insn_t      core_insn_o
);
  import socket_pkg::*;
  import core_io_pkg::*;

  // RAM data port.
  logic [MEM_AW-1:0] ram_addr;
  logic              ram_wr;
  word_t             ram_din;
  word_t             ram_dout;

  // Register strobes.
  logic     reg_wr;
  logic     reg_rd;
  wb_addr_t reg_off;
  word_t    reg_wdata;
  word_t    reg_rdata;

  logic  core_run;
  word_t gp_in;
  word_t gp_out;

  // Mailbox traffic.
  logic  rx_load;
  byte_t rx_load_byte;
  logic  tx_ack;
  logic  rx_take;
  logic  tx_load;
  byte_t tx_load_byte;
  byte_t rx_byte;
  logic  rx_avail;
  byte_t tx_byte;
  logic  tx_busy;

  // Core reset follows ctrl bit 0.
  assign core_rst_n_o   = core_run;
  assign core_mem_din_o = ram_dout;

  wb_host_port u_host (
    .sys_clk(sys_clk), .rst(rst),
    .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
    .wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i),
    .wbs_ack_o(wbs_ack_o), .wbs_dat_o(wbs_dat_o),
    .core_run_i(core_run), .core_addr_i(core_mem_addr_i),
    .core_wr_i(core_mem_wr_i), .core_dout_i(core_dout_i),
    .ram_addr_o(ram_addr), .ram_wr_o(ram_wr), .ram_din_o(ram_din), .ram_dout_i(ram_dout),
    .reg_wr_o(reg_wr), .reg_rd_o(reg_rd), .reg_off_o(reg_off),
    .reg_wdata_o(reg_wdata), .reg_rdata_i(reg_rdata)
  );

  prog_ram u_ram (
    .sys_clk(sys_clk),
    .a_addr_i(ram_addr), .a_wr_i(ram_wr), .a_din_i(ram_din), .a_dout_o(ram_dout),
    .b_addr_i(core_code_addr_i), .b_insn_o(core_insn_o)
  );

  host_regs u_regs (
    .sys_clk(sys_clk), .rst(rst),
    .reg_wr_i(reg_wr), .reg_rd_i(reg_rd), .reg_off_i(reg_off),
    .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
    .irq_in_i(irq_in_i), .core_run_o(core_run), .gp_in_o(gp_in),
    .rx_load_o(rx_load), .rx_byte_o(rx_load_byte), .tx_ack_o(tx_ack),
    .rx_byte_i(rx_byte), .rx_avail_i(rx_avail), .tx_byte_i(tx_byte), .tx_busy_i(tx_busy),
    .gp_out_i(gp_out)
  );

  uart_mailbox u_mbox (
    .sys_clk(sys_clk), .rst(rst),
    .rx_load_i(rx_load), .rx_byte_i(rx_load_byte), .rx_take_i(rx_take),
    .rx_byte_o(rx_byte), .rx_avail_o(rx_avail),
    .tx_load_i(tx_load), .tx_byte_i(tx_load_byte), .tx_ack_i(tx_ack),
    .tx_byte_o(tx_byte), .tx_busy_o(tx_busy)
  );

  core_io_bridge u_io (
    .sys_clk(sys_clk), .rst(rst),
    .core_mem_addr_i(core_mem_addr_i), .core_io_rd_i(core_io_rd_i),
    .core_io_wr_i(core_io_wr_i), .core_dout_i(core_dout_i),
    .core_io_din_o(core_io_din_o), .gp_in_i(gp_in), .gp_out_o(gp_out),
    .rx_byte_i(rx_byte), .rx_avail_i(rx_avail), .rx_take_o(rx_take),
    .tx_busy_i(tx_busy), .tx_load_o(tx_load), .tx_byte_o(tx_load_byte)
  );

endmodule

// ==== sim/clk_gen.sv ====
// ##########################################################
// Testbench clock and reset generator.
// 20 ns clock, reset held high for four cycles.
// ##########################################################
`timescale 1ns/1ps

module clk_gen (
  output logic sys_clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD_NS = 10;
  localparam int RST_CYCLES     = 4;

  // Free-running clock.
  initial begin
    sys_clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) sys_clk_o = ~sys_clk_o;
  end

  // Reset is released on a rising edge.
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge sys_clk_o);
    rst_o <= 1'b0;
  end

endmodule

// ==== sim/tb_forth_socket.sv ====
// ##########################################################
// Testbench for the Forth CPU socket frontend.
// Plays host and core and checks against a reference model.
// Covers registers, program load, data port, mailbox, GPIO
// and the timebase.
// ##########################################################
`timescale 1ns/1ps

module tb_forth_socket;
  import socket_pkg::*;
  import core_io_pkg::*;

  // Test sizes.
  localparam int N_REG     = 16;
  localparam int N_MEM     = 64;
  localparam int N_FETCH   = 32;
  localparam int N_CORE    = 32;
  localparam int N_MBOX    = 8;
  localparam int N_GPIO    = 32;
  localparam int MAX_GAP   = 200;
  localparam int ACK_LIMIT = 8;

  // Ten 20 ns cycles per operation, plus the timebase wait and margin.
  localparam int OP_COUNT = 5 * N_REG + 2 * N_MEM + N_FETCH + 3 * N_CORE
                          + 10 * N_MBOX + 3 * N_GPIO + 20;
  localparam longint WATCHDOG_NS = (OP_COUNT * 10 + 2 * MAX_GAP + 500) * 20;

  logic       sys_clk;
  logic       rst;
  logic       wbs_cyc;
  logic       wbs_stb;
  logic       wbs_we;
  wb_addr_t   wbs_adr;
  word_t      wbs_dat_w;
  logic       wbs_ack;
  word_t      wbs_dat_r;
  word_t      irq_in;
  logic       core_rst_n;
  io_addr_t   core_mem_addr;
  logic       core_mem_wr;
  word_t      core_dout;
  logic       core_io_rd;
  logic       core_io_wr;
  word_t      core_mem_din;
  word_t      core_io_din;
  code_addr_t core_code_addr;
  insn_t      core_insn;

  // Reference model state.
  word_t model_mem [MEM_WORDS];
  int    mem_addrs [$];
  int    low_addrs [$];
  word_t model_ctrl;
  word_t model_gp_in;
  word_t model_gp_out;
  word_t model_irq;
  byte_t model_rx_byte;
  byte_t model_tx_byte;
  logic  model_rx_avail;
  logic  model_tx_busy;

  clk_gen u_clk (
    .sys_clk_o(sys_clk),
    .rst_o(rst)
  );

  forth_socket_top dut (
    .sys_clk(sys_clk), .rst(rst),
    .wbs_cyc_i(wbs_cyc), .wbs_stb_i(wbs_stb), .wbs_we_i(wbs_we),
    .wbs_adr_i(wbs_adr), .wbs_dat_i(wbs_dat_w),
    .wbs_ack_o(wbs_ack), .wbs_dat_o(wbs_dat_r),
    .irq_in_i(irq_in), .core_rst_n_o(core_rst_n),
    .core_mem_addr_i(core_mem_addr), .core_mem_wr_i(core_mem_wr),
    .core_dout_i(core_dout), .core_io_rd_i(core_io_rd), .core_io_wr_i(core_io_wr),
    .core_mem_din_o(core_mem_din), .core_io_din_o(core_io_din),
    .core_code_addr_i(core_code_addr), .core_insn_o(core_insn)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "stopped at %0t ns", $time);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("mismatch at %0t ns: %s got %0h expected %0h",
                                  $time, name, got, exp));
    end
  endtask

  // One host cycle.
  // Stb is held until ack, and ack is sampled mid-cycle.
  task automatic host_access(input logic we, input wb_addr_t adr, input word_t wdata,
                             output word_t rdata);
    int waited = 0;
    @(posedge sys_clk);
    wbs_cyc   <= 1'b1;
    wbs_stb   <= 1'b1;
    wbs_we    <= we;
    wbs_adr   <= adr;
    wbs_dat_w <= wdata;
    do begin
      @(negedge sys_clk);
      waited++;
      if (waited > ACK_LIMIT) begin
        stop_with_failure("host port gave no acknowledge");
      end
    end while (wbs_ack !== 1'b1);
    rdata = wbs_dat_r;
    // Drop stb after ack.
    @(posedge sys_clk);
    wbs_cyc <= 1'b0;
    wbs_stb <= 1'b0;
    wbs_we  <= 1'b0;
  endtask

  task automatic host_write(input wb_addr_t adr, input word_t data);
    word_t unused;
    host_access(1'b1, adr, data, unused);
  endtask

  task automatic host_read(input wb_addr_t adr, output word_t data);
    host_access(1'b0, adr, '0, data);
  endtask

  // Core data port accesses use byte addresses and one-cycle timing.
  task automatic core_mem_write(input int word_adr, input word_t data);
    @(posedge sys_clk);
    core_mem_addr <= io_addr_t'(word_adr * 4);
    core_mem_wr   <= 1'b1;
    core_dout     <= data;
    @(posedge sys_clk);
    core_mem_wr <= 1'b0;
  endtask

  task automatic core_mem_read(input int word_adr, output word_t data);
    @(posedge sys_clk);
    core_mem_addr <= io_addr_t'(word_adr * 4);
    @(posedge sys_clk);
    @(negedge sys_clk);
    data = core_mem_din;
  endtask

  task automatic core_io_write(input io_addr_t adr, input word_t data);
    @(posedge sys_clk);
    core_mem_addr <= adr;
    core_io_wr    <= 1'b1;
    core_dout     <= data;
    @(posedge sys_clk);
    core_io_wr <= 1'b0;
  endtask

  task automatic core_io_read(input io_addr_t adr, output word_t data);
    @(posedge sys_clk);
    core_mem_addr <= adr;
    core_io_rd    <= 1'b1;
    @(posedge sys_clk);
    core_io_rd <= 1'b0;
    @(negedge sys_clk);
    data = core_io_din;
  endtask

  task automatic core_fetch(input code_addr_t code, output insn_t insn);
    @(posedge sys_clk);
    core_code_addr <= code;
    @(posedge sys_clk);
    @(negedge sys_clk);
    insn = core_insn;
  endtask

  // Expected UART status word.
  // Bit 1 is rx_avail and bit 0 is ready.
  function automatic word_t stat_word();
    return {30'b0, model_rx_avail, ~model_tx_busy};
  endfunction

  // Watchdog.
  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("watchdog expired before the tests finished");
  end

  initial begin
    int unsigned seed_draw;
    word_t       v;
    word_t       got;
    word_t       lo;
    word_t       hi;
    logic [63:0] snap_a;
    logic [63:0] snap_b;
    int          adr;
    int          bitn;
    int          gap;
    byte_t       b;
    code_addr_t  code;
    insn_t       insn;

    seed_draw = $urandom(32'h9a80);
    wbs_cyc        <= 1'b0;
    wbs_stb        <= 1'b0;
    wbs_we         <= 1'b0;
    wbs_adr        <= '0;
    wbs_dat_w      <= '0;
    irq_in         <= '0;
    core_mem_addr  <= '0;
    core_mem_wr    <= 1'b0;
    core_dout      <= '0;
    core_io_rd     <= 1'b0;
    core_io_wr     <= 1'b0;
    core_code_addr <= '0;
    model_ctrl     = '0;
    model_gp_in    = '0;
    model_gp_out   = '0;
    model_irq      = '0;
    model_rx_avail = 1'b0;
    model_tx_busy  = 1'b0;

    wait (rst === 1'b0);
    @(negedge sys_clk);
    check("wbs_ack_o after reset", wbs_ack, 0);
    check("core_rst_n_o after reset", core_rst_n, 0);
    host_read(REG_BASE + REG_CTRL, got);
    check("REG_CTRL after reset", got, 0);
    host_read(REG_BASE + REG_GP_IN, got);
    check("REG_GP_IN after reset", got, 0);
    host_read(REG_BASE + REG_GP_OUT, got);
    check("REG_GP_OUT after reset", got, 0);
    core_io_read(IO_UART_STAT, got);
    check("UART status after reset", got, stat_word());
    core_io_read(IO_CLK_LO, got);
    check("snapshot after reset", got, 0);

    // Registers.
    host_read(REG_SIG_ADDR, got);
    check("signature", got, SIGNATURE);
    for (int i = 0; i < N_REG; i++) begin
      model_ctrl = $urandom & 32'hffff_fffe;
      host_write(REG_BASE + REG_CTRL, model_ctrl);
      host_read(REG_BASE + REG_CTRL, got);
      check("REG_CTRL", got, model_ctrl);
      model_gp_in = $urandom;
      host_write(REG_BASE + REG_GP_IN, model_gp_in);
      host_read(REG_BASE + REG_GP_IN, got);
      check("REG_GP_IN", got, model_gp_in);
      // irq_in stays put for at least two cycles before the read.
      @(posedge sys_clk);
      model_irq = $urandom;
      irq_in <= model_irq;
      host_read(REG_BASE + REG_IRQ_IN, got);
      check("REG_IRQ_IN", got, model_irq);
    end

    // Program load with the core held in reset.
    for (int i = 0; i < N_MEM; i++) begin
      // Every other word lands where the fetch port can see it.
      adr = (i % 2 == 0) ? $urandom % (MEM_WORDS / 2) : $urandom % MEM_WORDS;
      v = $urandom;
      host_write(wb_addr_t'(adr), v);
      model_mem[adr] = v;
      mem_addrs.push_back(adr);
      if (adr < MEM_WORDS / 2) begin
        low_addrs.push_back(adr);
      end
    end
    foreach (mem_addrs[i]) begin
      host_read(wb_addr_t'(mem_addrs[i]), got);
      check("host memory read", got, model_mem[mem_addrs[i]]);
    end
    model_ctrl = 32'h1;
    host_write(REG_BASE + REG_CTRL, model_ctrl);
    @(negedge sys_clk);
    check("core_rst_n_o", core_rst_n, 1);
    for (int i = 0; i < N_FETCH; i++) begin
      adr = low_addrs[$urandom % low_addrs.size()];
      code = code_addr_t'(adr * 2 + ($urandom % 2));
      core_fetch(code, insn);
      v = model_mem[adr];
      // Low half-word is the even instruction.
      check("core_insn_o", insn, code[0] ? v[31:16] : v[15:0]);
    end

    // Core data port while the core runs.
    for (int i = 0; i < N_CORE; i++) begin
      adr = $urandom % MEM_WORDS;
      v = $urandom;
      core_mem_write(adr, v);
      model_mem[adr] = v;
      mem_addrs.push_back(adr);
      adr = mem_addrs[$urandom % mem_addrs.size()];
      core_mem_read(adr, got);
      check("core_mem_din_o", got, model_mem[adr]);
      if (i % 4 == 0) begin
        // A host write is dropped and the old word stays.
        host_write(wb_addr_t'(adr), ~model_mem[adr]);
        core_mem_read(adr, got);
        check("core_mem_din_o after host write", got, model_mem[adr]);
      end
    end

    // Mailbox in both directions.
    for (int i = 0; i < N_MBOX; i++) begin
      b = byte_t'($urandom);
      host_write(REG_BASE + REG_RX, ($urandom & 32'hffff_ff00) | b);
      model_rx_byte  = b;
      model_rx_avail = 1'b1;
      host_read(REG_BASE + REG_RX, got);
      check("REG_RX", got, {23'b0, model_rx_avail, model_rx_byte});
      core_io_read(IO_UART_STAT, got);
      check("UART status with rx byte", got, stat_word());
      core_io_read(IO_UART_DATA, got);
      check("UART data", got, {24'b0, model_rx_byte});
      model_rx_avail = 1'b0;
      core_io_read(IO_UART_STAT, got);
      check("UART status after take", got, stat_word());
      b = byte_t'($urandom);
      core_io_write(IO_UART_DATA, ($urandom & 32'hffff_ff00) | b);
      model_tx_byte = b;
      model_tx_busy = 1'b1;
      core_io_read(IO_UART_STAT, got);
      check("UART status with tx byte", got, stat_word());
      host_read(REG_BASE + REG_TX, got);
      check("REG_TX busy", got, {23'b0, model_tx_busy, model_tx_byte});
      model_tx_busy = 1'b0;
      host_read(REG_BASE + REG_TX, got);
      check("REG_TX idle", got, {23'b0, model_tx_busy, model_tx_byte});
    end

    // GPIO outputs and then GPIO inputs.
    model_gp_in = $urandom;
    host_write(REG_BASE + REG_GP_IN, model_gp_in);
    for (int i = 0; i < N_GPIO; i++) begin
      bitn = $urandom % 32;
      v = $urandom;
      core_io_write({8'h00, 3'($urandom), 5'(bitn)}, v);
      model_gp_out[bitn] = v[0];
      if (i % 8 == 7) begin
        host_read(REG_BASE + REG_GP_OUT, got);
        check("REG_GP_OUT", got, model_gp_out);
      end
    end
    for (int i = 0; i < N_GPIO; i++) begin
      bitn = $urandom % 32;
      core_io_read({8'h00, 3'($urandom), 5'(bitn)}, got);
      check("GPIO read", got, {31'b0, model_gp_in[bitn]});
    end

    // Timebase.
    core_io_read(IO_FREQ, got);
    check("IO_FREQ", got, 32'd50_000_000);
    core_io_write(IO_FREQ, $urandom);
    core_io_read(IO_CLK_LO, lo);
    core_io_read(IO_CLK_LO, got);
    check("IO_CLK_LO second read", got, lo);
    core_io_read(IO_CLK_HI, hi);
    snap_a = {hi, lo};
    gap = 1 + $urandom % MAX_GAP;
    repeat (gap) @(posedge sys_clk);
    core_io_write(IO_FREQ, $urandom);
    core_io_read(IO_CLK_LO, lo);
    core_io_read(IO_CLK_HI, hi);
    snap_b = {hi, lo};
    if (snap_b < snap_a || snap_b - snap_a < 64'(gap)) begin
      stop_with_failure($sformatf("second snapshot %0h is not %0d cycles past %0h",
                                  snap_b, gap, snap_a));
    end
    // Well under one millisecond has passed.
    core_io_read(IO_MS, got);
    check("IO_MS", got, 0);

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/socket_pkg.sv
hdl/core_io_pkg.sv
hdl/prog_ram.sv
hdl/wb_host_port.sv
hdl/host_regs.sv
hdl/uart_mailbox.sv
hdl/core_io_bridge.sv
hdl/forth_socket_top.sv
sim/clk_gen.sv
sim/tb_forth_socket.sv

// ==== Bender.yml ====
package:
  name: forth_socket

sources:
  # Packages first, then the frontend blocks and the top level.
  - hdl/socket_pkg.sv
  - hdl/core_io_pkg.sv
  - hdl/prog_ram.sv
  - hdl/wb_host_port.sv
  - hdl/host_regs.sv
  - hdl/uart_mailbox.sv
  - hdl/core_io_bridge.sv
  - hdl/forth_socket_top.sv

  # Testbench, top module tb_forth_socket.
  - target: test
    files:
      - sim/clk_gen.sv
      - sim/tb_forth_socket.sv
